//--- verilog/ig_pkg.sv
package ig_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int PIX_W    = 8;
    localparam int GRAD_W   = 10;
    localparam int ADDR_W   = 16;
    localparam int CREDIT_W = 8;

    // ----------------------------------------
    // data types
    // ----------------------------------------
    // one greyscale sample
    typedef logic [PIX_W-1:0] pixel_t;

    // one gradient component, range -255 to 255
    typedef logic signed [GRAD_W-1:0] grad_comp_t;

    // gx in the upper half, gy in the lower half
    typedef logic [2*GRAD_W-1:0] grad_word_t;

    // address into image or gradient memory
    typedef logic [ADDR_W-1:0] mem_addr_t;

    // credit counters, internal and external
    typedef logic [CREDIT_W-1:0] credit_t;

    // ----------------------------------------
    // state machines
    // ----------------------------------------
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_RUN,
        FETCH_END
    } fetch_state_t;

    typedef enum logic {
        WR_RUN,
        WR_DONE
    } writer_state_t;

endpackage

//--- verilog/pixel_fetch.sv
module pixel_fetch #(
    parameter int IMG_W      = 256,
    parameter int IMG_H      = 256,
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  ig_pkg::pixel_t    img_di,
    input  logic              credit_return,
    output logic              img_rd,
    output ig_pkg::mem_addr_t img_addr,
    output logic              pix_valid,
    output ig_pkg::pixel_t    pix
);
    import ig_pkg::*;

    localparam mem_addr_t LAST_COL     = mem_addr_t'(IMG_W - 1);
    localparam mem_addr_t LAST_ROW     = mem_addr_t'(IMG_H - 1);
    localparam credit_t   INIT_CREDITS = credit_t'(FIFO_DEPTH);

    fetch_state_t state;
    mem_addr_t    col;
    mem_addr_t    row;
    mem_addr_t    addr;
    credit_t      credits;
    logic         producing;
    logic         issue;
    logic         last_pix;
    logic         rd_pending;

    // pixel that will finish a gradient in the core
    assign producing = (row != '0) && (col != LAST_COL);
    // producing reads stall without a credit, the others never do
    assign issue     = (state != FETCH_END) && !(producing && (credits == '0));
    assign last_pix  = (col == LAST_COL) && (row == LAST_ROW);

    // ----------------------------------------
    // raster address generator
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= FETCH_IDLE;
            col    <= '0;
            row    <= '0;
            addr   <= '0;
            img_rd <= 1'b0;
        end else begin
            img_rd <= issue;
            if (issue) begin
                addr  <= addr + 1'b1;
                state <= last_pix ? FETCH_END : FETCH_RUN;
                if (col == LAST_COL) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            img_addr <= addr;
        end
    end

    // internal credits, one per gradient in flight
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= INIT_CREDITS;
        end else begin
            case ({issue && producing, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // ----------------------------------------
    // read response
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pending <= 1'b0;
            pix_valid  <= 1'b0;
        end else begin
            rd_pending <= img_rd;
            pix_valid  <= rd_pending;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pending) begin
            pix <= img_di;
        end
    end

endmodule

//--- verilog/gradient_core.sv
module gradient_core #(
    parameter int IMG_W = 256,
    parameter int IMG_H = 256
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               pix_valid,
    input  ig_pkg::pixel_t     pix,
    output logic               grad_valid,
    output ig_pkg::grad_word_t grad,
    output ig_pkg::mem_addr_t  grad_index
);
    import ig_pkg::*;

    localparam mem_addr_t LAST_COL = mem_addr_t'(IMG_W - 1);
    localparam mem_addr_t LAST_ROW = mem_addr_t'(IMG_H - 1);

    // line_q[k] holds the pixel k+1 positions back
    pixel_t     line_q [IMG_W];
    mem_addr_t  col;
    mem_addr_t  row;
    mem_addr_t  pix_idx;
    pixel_t     tap_up;
    pixel_t     tap_up_right;
    grad_comp_t gx;
    grad_comp_t gy;
    logic       producing;

    // ----------------------------------------
    // taps and subtractors
    // ----------------------------------------
    // arriving pixel sits below tap_up, tap_up_right is its right neighbour
    assign tap_up       = line_q[IMG_W-1];
    assign tap_up_right = line_q[IMG_W-2];

    assign gx = grad_comp_t'({2'b00, tap_up_right}) - grad_comp_t'({2'b00, tap_up});
    assign gy = grad_comp_t'({2'b00, pix}) - grad_comp_t'({2'b00, tap_up});

    assign producing = (row != '0) && (row <= LAST_ROW) && (col != LAST_COL);

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            line_q[0] <= pix;
            for (int i = 1; i < IMG_W; i++) begin
                line_q[i] <= line_q[i-1];
            end
        end
    end

    // own position counters, independent of the fetcher
    always_ff @(posedge clk) begin
        if (reset) begin
            col        <= '0;
            row        <= '0;
            pix_idx    <= '0;
            grad_valid <= 1'b0;
        end else begin
            grad_valid <= pix_valid && producing;
            if (pix_valid) begin
                pix_idx <= pix_idx + 1'b1;
                if (col == LAST_COL) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // result belongs to the pixel one row up
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            grad       <= {gx, gy};
            grad_index <= pix_idx - mem_addr_t'(IMG_W);
        end
    end

endmodule

//--- verilog/grad_writer.sv
module grad_writer #(
    parameter int IMG_W        = 256,
    parameter int IMG_H        = 256,
    parameter int FIFO_DEPTH   = 4,
    parameter int GRAD_CREDITS = 2
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               grad_valid,
    input  ig_pkg::grad_word_t grad,
    input  ig_pkg::mem_addr_t  grad_index,
    input  logic               grad_credit,
    output logic               credit_return,
    output logic               grad_wr,
    output ig_pkg::mem_addr_t  grad_addr,
    output ig_pkg::grad_word_t grad_do,
    output logic               done
);
    import ig_pkg::*;

    localparam int               PTR_W        = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR     = PTR_W'(FIFO_DEPTH - 1);
    localparam mem_addr_t        LAST_WRITE   = mem_addr_t'((IMG_W - 1) * (IMG_H - 1) - 1);
    localparam credit_t          INIT_CREDITS = credit_t'(GRAD_CREDITS);

    grad_word_t       data_q [FIFO_DEPTH];
    mem_addr_t        addr_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    credit_t          fill;
    credit_t          ext_credits;
    mem_addr_t        wr_count;
    writer_state_t    state;
    logic             fifo_empty;
    logic             pop;
    logic             fifo_pop;
    logic             push;

    // ----------------------------------------
    // queue with fall-through when empty
    // ----------------------------------------
    assign fifo_empty = (fill == '0);
    assign pop        = (state == WR_RUN) && (!fifo_empty || grad_valid) && (ext_credits != '0);
    assign fifo_pop   = pop && !fifo_empty;
    // a gradient written straight through skips the queue
    assign push       = grad_valid && !(pop && fifo_empty);

    always_ff @(posedge clk) begin
        if (push) begin
            data_q[wr_ptr] <= grad;
            addr_q[wr_ptr] <= grad_index;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (fifo_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, fifo_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // ----------------------------------------
    // memory writes, external credits, done
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (pop) begin
            grad_do   <= fifo_empty ? grad : data_q[rd_ptr];
            grad_addr <= fifo_empty ? grad_index : addr_q[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= WR_RUN;
            ext_credits   <= INIT_CREDITS;
            wr_count      <= '0;
            grad_wr       <= 1'b0;
            credit_return <= 1'b0;
            done          <= 1'b0;
        end else begin
            grad_wr       <= pop;
            credit_return <= pop;
            // done follows the last write by one edge
            done          <= (state == WR_DONE);
            case ({pop, grad_credit})
                2'b10:   ext_credits <= ext_credits - 1'b1;
                2'b01:   ext_credits <= ext_credits + 1'b1;
                default: ext_credits <= ext_credits;
            endcase
            if (pop) begin
                wr_count <= wr_count + 1'b1;
                if (wr_count == LAST_WRITE) begin
                    state <= WR_DONE;
                end
            end
        end
    end

endmodule

//--- verilog/ig_top.sv
module ig_top #(
    parameter int IMG_W        = 256,
    parameter int IMG_H        = 256,
    parameter int FIFO_DEPTH   = 4,
    parameter int GRAD_CREDITS = 2
) (
    input  logic               clk,
    input  logic               reset,
    output logic               img_rd,
    output ig_pkg::mem_addr_t  img_addr,
    input  ig_pkg::pixel_t     img_di,
    output logic               grad_wr,
    output ig_pkg::mem_addr_t  grad_addr,
    output ig_pkg::grad_word_t grad_do,
    input  logic               grad_credit,
    output logic               done
);
    import ig_pkg::*;

    // fetch to core
    logic       pix_valid;
    pixel_t     pix;

    // core to writer
    logic       grad_valid;
    grad_word_t grad;
    mem_addr_t  grad_index;

    // writer back to fetch
    logic       credit_return;

    pixel_fetch #(
        .IMG_W      (IMG_W),
        .IMG_H      (IMG_H),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fetch (
        .clk           (clk),
        .reset         (reset),
        .img_di        (img_di),
        .credit_return (credit_return),
        .img_rd        (img_rd),
        .img_addr      (img_addr),
        .pix_valid     (pix_valid),
        .pix           (pix)
    );

    gradient_core #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_core (
        .clk        (clk),
        .reset      (reset),
        .pix_valid  (pix_valid),
        .pix        (pix),
        .grad_valid (grad_valid),
        .grad       (grad),
        .grad_index (grad_index)
    );

    grad_writer #(
        .IMG_W        (IMG_W),
        .IMG_H        (IMG_H),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .GRAD_CREDITS (GRAD_CREDITS)
    ) u_writer (
        .clk           (clk),
        .reset         (reset),
        .grad_valid    (grad_valid),
        .grad          (grad),
        .grad_index    (grad_index),
        .grad_credit   (grad_credit),
        .credit_return (credit_return),
        .grad_wr       (grad_wr),
        .grad_addr     (grad_addr),
        .grad_do       (grad_do),
        .done          (done)
    );

endmodule

//--- tests/tb_clock.sv
module tb_clock #(
    parameter int HALF_PERIOD = 4
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

//--- tests/ig_props.sv
module ig_props #(
    parameter int GRAD_CREDITS = 2
) (
    input logic clk,
    input logic reset,
    input logic img_rd,
    input logic grad_wr,
    input logic grad_credit,
    input logic done
);
    timeunit 1ns;
    timeprecision 100ps;

    // external credits held by the engine, seen from the memory side
    int held;

    always @(posedge clk) begin
        if (reset) begin
            held <= GRAD_CREDITS;
        end else begin
            held <= held - int'(grad_wr) + int'(grad_credit);
        end
    end

    // ----------------------------------------
    // handshake properties
    // ----------------------------------------
    // a write consumes a credit, so one must be held
    a_wr_needs_credit: assert property (
        @(posedge clk) disable iff (reset) grad_wr |-> (held > 0)
    ) else $error("grad_wr while no external credit is held");

    // done is sticky until the next reset
    a_done_sticky: assert property (
        @(posedge clk) disable iff (reset) done |=> done
    ) else $error("done fell without a reset");

    // outputs cleared by every reset edge
    a_quiet_in_reset: assert property (
        @(posedge clk) reset |=> (!img_rd && !grad_wr)
    ) else $error("img_rd or grad_wr high while reset is held");

endmodule

bind ig_top ig_props #(
    .GRAD_CREDITS (GRAD_CREDITS)
) u_props (
    .clk         (clk),
    .reset       (reset),
    .img_rd      (img_rd),
    .grad_wr     (grad_wr),
    .grad_credit (grad_credit),
    .done        (done)
);

//--- tests/ig_tb.sv
module ig_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import ig_pkg::*;

    localparam int IMG_W        = 8;
    localparam int IMG_H        = 6;
    localparam int FIFO_DEPTH   = 4;
    localparam int GRAD_CREDITS = 2;
    localparam int NPIX         = IMG_W * IMG_H;
    localparam int NGRAD        = (IMG_W - 1) * (IMG_H - 1);
    localparam int NROWS        = 4;
    localparam int MAX_DELAY    = 7;
    localparam int RESET_CYCLES = 4;
    localparam int WATCHDOG     = NROWS * NPIX * (MAX_DELAY + 4) + 100;

    localparam int IMG_RANDOM = 0;
    localparam int IMG_ZERO   = 1;
    localparam int IMG_RAMP   = 2;

    // ----------------------------------------
    // test table: image kind, credit delay
    // ----------------------------------------
    int row_kind  [NROWS] = '{IMG_RANDOM, IMG_ZERO, IMG_RAMP, IMG_RANDOM};
    int row_delay [NROWS] = '{0, 3, 1, 7};

    logic       clk;
    logic       reset       = 1'b1;
    logic       img_rd;
    mem_addr_t  img_addr;
    pixel_t     img_di      = '0;
    logic       grad_wr;
    mem_addr_t  grad_addr;
    grad_word_t grad_do;
    logic       grad_credit = 1'b0;
    logic       done;

    // memory models and monitor state
    pixel_t     img_mem [NPIX];
    logic       rst_q        = 1'b0;
    logic       rd_pend      = 1'b0;
    mem_addr_t  rd_pend_addr = '0;
    logic       done_seen    = 1'b0;
    int         credit_due [$];
    int         rd_next      = 0;
    int         wr_count     = 0;
    int         outstanding  = 0;
    int         cycle        = 0;
    int         exp_addr     = 0;
    int         cur_delay    = 0;
    int         value_errors = 0;
    int         other_errors = 0;
    int         seed         = 32'had09_cf4d;

    tb_clock clock_gen (.clk(clk));

    ig_top #(
        .IMG_W        (IMG_W),
        .IMG_H        (IMG_H),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .GRAD_CREDITS (GRAD_CREDITS)
    ) UUT (
        .clk         (clk),
        .reset       (reset),
        .img_rd      (img_rd),
        .img_addr    (img_addr),
        .img_di      (img_di),
        .grad_wr     (grad_wr),
        .grad_addr   (grad_addr),
        .grad_do     (grad_do),
        .grad_credit (grad_credit),
        .done        (done)
    );

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("[ERROR] %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        value_errors++;
    endtask

    task automatic report_failure(string what);
        $display("error at %0t ns: %s", $time, what);
        other_errors++;
    endtask

    task automatic load_image(int kind);
        logic [31:0] rnd;
        int          x;
        int          y;
        for (int a = 0; a < NPIX; a++) begin
            x = a % IMG_W;
            y = a / IMG_W;
            case (kind)
                IMG_RANDOM: begin
                    rnd        = $random(seed);
                    img_mem[a] = rnd[7:0];
                end
                IMG_ZERO: begin
                    img_mem[a] = '0;
                end
                default: begin
                    // checkerboard of 0 and 255 on top, ramp up to 255 below
                    if (y < IMG_H / 2) begin
                        img_mem[a] = ((x + y) % 2 == 1) ? 8'd255 : 8'd0;
                    end else begin
                        img_mem[a] = pixel_t'(a * 255 / (NPIX - 1));
                    end
                end
            endcase
        end
    endtask

    // Gx = right minus self, Gy = below minus self
    function automatic grad_word_t expected_word(int a);
        int gx;
        int gy;
        gx = int'(img_mem[a + 1]) - int'(img_mem[a]);
        gy = int'(img_mem[a + IMG_W]) - int'(img_mem[a]);
        return {gx[9:0], gy[9:0]};
    endfunction

    // ----------------------------------------
    // image memory, gradient memory, checks
    // ----------------------------------------
    always @(posedge clk) begin
        rst_q <= reset;
    end

    always @(negedge clk) begin
        if (rst_q) begin
            assert (!img_rd && !grad_wr && !done)
                else report_failure("img_rd, grad_wr or done high during reset");
            rd_pend     = 1'b0;
            done_seen   = 1'b0;
            rd_next     = 0;
            wr_count    = 0;
            outstanding = 0;
            grad_credit = 1'b0;
            img_di      = '0;
            credit_due.delete();
        end else begin
            cycle++;
            // answer the read taken one cycle ago
            if (rd_pend) begin
                img_di = img_mem[rd_pend_addr];
            end
            rd_pend      = img_rd;
            rd_pend_addr = img_addr;
            if (img_rd) begin
                assert (rd_next < NPIX) else report_failure("read past the last image address");
                assert (img_addr == mem_addr_t'(rd_next))
                    else report_mismatch("img_addr", img_addr, rd_next);
                rd_next++;
            end

            if (grad_wr) begin
                exp_addr = (wr_count / (IMG_W - 1)) * IMG_W + wr_count % (IMG_W - 1);
                assert (!done_seen) else report_failure("gradient write after done");
                assert (wr_count < NGRAD) else report_failure("more writes than gradients");
                assert (grad_addr == mem_addr_t'(exp_addr))
                    else report_mismatch("grad_addr", grad_addr, exp_addr);
                assert (grad_do == expected_word(exp_addr))
                    else report_mismatch("grad_do", grad_do, expected_word(exp_addr));
                wr_count++;
                outstanding++;
                assert (outstanding <= GRAD_CREDITS)
                    else report_failure("more writes outstanding than credits");
                credit_due.push_back(cycle + 1 + cur_delay);
            end

            // one-cycle credit pulse per freed slot
            grad_credit = 1'b0;
            if (credit_due.size() > 0 && credit_due[0] == cycle) begin
                void'(credit_due.pop_front());
                grad_credit = 1'b1;
                outstanding--;
            end

            if (done) begin
                if (!done_seen) begin
                    assert (wr_count == NGRAD) else report_failure("done rose before the last write");
                end
                done_seen = 1'b1;
            end else begin
                assert (!done_seen) else report_failure("done fell before reset");
            end
        end
    end

    task automatic run_row(int r);
        @(negedge clk);
        reset = 1'b1;
        @(posedge clk);
        load_image(row_kind[r]);
        cur_delay = row_delay[r];
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (!done) begin
            @(negedge clk);
        end
        // late credits come back, late writes would show up here
        repeat (MAX_DELAY + 4) @(negedge clk);
        assert (rd_next == NPIX) else report_failure("not every image address was read");
        assert (wr_count == NGRAD) else report_failure("not every gradient was written");
        assert (outstanding == 0) else report_failure("credits still outstanding after done");
    endtask

    initial begin
        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout: the table did not finish within %0d cycles", WATCHDOG);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- flist.f
verilog/ig_pkg.sv
verilog/pixel_fetch.sv
verilog/gradient_core.sv
verilog/grad_writer.sv
verilog/ig_top.sv
tests/tb_clock.sv
tests/ig_props.sv
tests/ig_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ig_tb -f flist.f -o ig_sim
./obj_dir/ig_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG" || ! grep -q "SIMULATION PASSED" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi
echo "simulation passed"
